// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int xlen = 32;
	localparam int shamt_w = $clog2(xlen);

	typedef logic [xlen-1:0] word_t;
	typedef logic [3:0] reg_idx_t;

	localparam reg_idx_t reg_zero = 4'd0;
	localparam reg_idx_t reg_lr = 4'd1;
	localparam reg_idx_t reg_sp = 4'd2;
	localparam reg_idx_t reg_mdhi = 4'd7;	// high half of mul/div

	typedef enum logic [3:0] {
		op_add   = 4'd0,
		op_sub   = 4'd1,
		op_xor   = 4'd2,
		op_or    = 4'd3,
		op_and   = 4'd4,
		op_sll   = 4'd5,
		op_sra   = 4'd6,
		op_srl   = 4'd7,
		op_addb  = 4'd8,
		op_addbu = 4'd9,
		op_swap  = 4'd10
	} alu_op_e;

	// on a jump, cond bit 0 set means link into lr
	typedef enum logic [2:0] {
		cond_eqz    = 3'b000,
		cond_nez    = 3'b001,
		cond_gez    = 3'b010,
		cond_ltz    = 3'b011,
		cond_always = 3'b111
	} br_cond_e;

	typedef struct packed {
		reg_idx_t  rd;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
		logic      needs_rs2;	// else b is imm
		word_t     imm;
		alu_op_e   op;
		br_cond_e  cond;
		logic      load;
		logic      store;
		logic      jmp;
		logic      br;
		logic      mult;
		logic      div;
		logic      byte_sz;
	} dec_inst_t;

	typedef struct packed {
		logic      valid;
		reg_idx_t  addr;
		word_t     data;
	} wb_t;

endpackage

`default_nettype wire

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

	import cpu_pkg::*;

	localparam int addr_w = xlen - 2;	// word address
	localparam int mask_w = xlen / 8;

	typedef logic [mask_w-1:0] wmask_t;
	typedef logic [addr_w-1:0] addr_t;
	typedef logic [xlen-1:1] pc_t;	// half-word fetch address

	localparam wmask_t wmask_all = '1;

	typedef struct packed {
		addr_t   addr;
		word_t   wdata;
		wmask_t  wmask;
		logic [1:0] rstrobe;	// one per half-word
	} mem_req_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  logic     needs_rs2,
	input  word_t    imm,
	input  wb_t      wb,
	input  word_t    md_hi,
	output word_t    a,
	output word_t    b,
	output word_t    store_val
);

	word_t r_lr, r_sp;
	word_t regs [8:15];
	word_t rs2_val;

	function automatic logic writable(reg_idx_t idx);
		return idx == reg_lr || idx == reg_sp || idx == reg_mdhi || idx[3];
	endfunction

	function automatic word_t read_port(reg_idx_t idx);
		word_t v;
		if (wb.valid && wb.addr == idx && writable(idx)) begin
			v = wb.data;	// bypass
		end else begin
			case (idx)
			reg_zero: v = '0;
			reg_lr:   v = r_lr;
			reg_sp:   v = r_sp;
			reg_mdhi: v = md_hi;
			default:  v = idx[3] ? regs[idx] : '0;	// r3 to r6 read as zero
			endcase
		end
		return v;
	endfunction

	always_comb begin
		a = read_port(rs1);
		rs2_val = read_port(rs2);
		b = needs_rs2 ? rs2_val : imm;
		store_val = rs2_val;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r_lr <= '0;
			r_sp <= '0;
		end else if (wb.valid) begin
			if (wb.addr == reg_lr)
				r_lr <= wb.data;
			if (wb.addr == reg_sp)
				r_sp <= wb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (wb.valid && wb.addr[3])
			regs[wb.addr] <= wb.data;	// r8..r15
	end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input  alu_op_e  op,
	input  br_cond_e cond,
	input  word_t    a,
	input  word_t    b,
	output word_t    result,
	output logic     taken
);

	logic [shamt_w-1:0] shamt;
	word_t sum, diff;

	assign shamt = b[shamt_w-1:0];
	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		case (op)
		op_add:   result = sum;
		op_sub:   result = diff;
		op_xor:   result = a ^ b;
		op_or:    result = a | b;
		op_and:   result = a & b;
		op_sll:   result = a << shamt;
		op_sra:   result = word_t'($signed(a) >>> shamt);
		op_srl:   result = a >> shamt;
		op_addb:  result = {{(xlen-8){sum[7]}}, sum[7:0]};
		op_addbu: result = {{(xlen-8){1'b0}}, sum[7:0]};
		op_swap:  result = {{(xlen-16){1'b0}}, b[7:0], b[15:8]};	// byte swap of low half
		default:  result = sum;
		endcase
	end

	always_comb begin
		case (cond)
		cond_eqz:    taken = a == '0;
		cond_nez:    taken = a != '0;
		cond_gez:    taken = !a[xlen-1];
		cond_ltz:    taken = a[xlen-1];
		cond_always: taken = 1'b1;
		default:     taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  start_mul,
	input  logic  start_div,
	input  word_t a,
	input  word_t b,
	input  wb_t   wb,
	output logic  busy,
	output logic  done,
	output word_t lo,
	output word_t md_hi
);

	typedef enum logic [1:0] {
		md_idle,
		md_mul,
		md_div
	} md_state_e;

	md_state_e r_state;
	logic [shamt_w-1:0] r_bit;	// operand bit, msb first
	logic r_done;
	word_t r_a, r_b;
	logic [2*xlen-1:0] r_md;	// hi = remainder, lo = quotient
	word_t t1;
	logic [xlen:0] t2;

	assign busy = r_state != md_idle;
	assign done = r_done;
	assign lo = r_md[xlen-1:0];
	assign md_hi = r_md[2*xlen-1:xlen];

	// restoring divide trial subtract
	always_comb begin
		t1 = {r_md[2*xlen-2:xlen], r_a[r_bit]};
		t2 = {1'b0, t1} - {1'b0, r_b};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r_state <= md_idle;
			r_done <= 1'b0;
			r_bit <= '1;
		end else begin
			r_done <= 1'b0;
			case (r_state)
			md_idle: begin
				if (start_mul)
					r_state <= md_mul;
				else if (start_div)
					r_state <= md_div;
			end
			default: begin
				if (r_bit == '0) begin
					r_state <= md_idle;
					r_done <= 1'b1;
				end
			end
			endcase
			r_bit <= busy ? r_bit - 1'b1 : '1;
		end
	end

	always_ff @(posedge clk) begin
		if (r_state == md_idle && (start_mul || start_div)) begin
			r_a <= a;
			r_b <= b;
			r_md <= '0;
		end else if (r_state == md_mul) begin
			r_md <= {r_md[2*xlen-2:0], 1'b0} + (r_a[r_bit] ? {{xlen{1'b0}}, r_b} : '0);
		end else if (r_state == md_div) begin
			if (r_b == '0)
				r_md <= '0;	// divide by zero
			else if (!t2[xlen])
				r_md <= {t2[xlen-1:0], r_md[xlen-2:0], 1'b1};
			else
				r_md <= {t1, r_md[xlen-2:0], 1'b0};
		end else if (wb.valid && wb.addr == reg_mdhi) begin
			r_md[2*xlen-1:xlen] <= wb.data;	// write to r7
		end
	end

endmodule

`default_nettype wire

// File: seq_control.sv
`timescale 1ns/1ps
`default_nettype none

module seq_control
	import cpu_pkg::*;
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  dec_inst_t inst,
	input  logic      iready,
	input  logic      idone,
	input  word_t     result,
	input  logic      taken,
	input  logic      md_busy,
	input  logic      md_done,
	input  word_t     md_lo,
	input  logic      load_wait,
	input  logic      store_wait,
	input  word_t     ld_data,
	output logic      accept,
	output pc_t       pc,
	output logic      ifetch,
	output wb_t       wb
);

	typedef enum logic [2:0] {
		st_fetch,
		st_execute,
		st_mem_wait,
		st_md_wait,
		st_bubble
	} state_e;

	state_e   r_state;
	pc_t      r_pc, pc_next;
	reg_idx_t r_rd;
	logic     r_load;
	wb_t      r_wb, wb_next;
	logic     redirect, link, mem_op, md_op, mem_end;

	assign accept = r_state == st_execute && iready && !md_busy;
	assign redirect = inst.jmp || (inst.br && taken);
	assign link = inst.jmp && inst.cond[0];
	assign mem_op = inst.load || inst.store;
	assign md_op = inst.mult || inst.div;
	assign mem_end = r_state == st_mem_wait && !load_wait && !store_wait;
	assign pc_next = r_pc + 1'b1;

	assign pc = r_pc;
	assign ifetch = r_state == st_fetch;
	assign wb = r_wb;

	always_ff @(posedge clk) begin
		if (reset) begin
			r_state <= st_fetch;
			r_pc <= '0;
			r_load <= 1'b0;
		end else begin
			case (r_state)
			st_fetch: if (idone) r_state <= st_execute;
			st_execute: begin
				if (accept) begin
					r_pc <= redirect ? result[xlen-1:1] : pc_next;
					r_load <= inst.load;
					if (mem_op)
						r_state <= st_mem_wait;
					else if (md_op)
						r_state <= st_md_wait;
					else if (redirect)
						r_state <= st_bubble;	// one dead cycle before refetch
					else
						r_state <= st_fetch;
				end
			end
			st_mem_wait: if (mem_end) r_state <= st_fetch;
			st_md_wait: if (md_done) r_state <= st_fetch;
			default: r_state <= st_fetch;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			r_rd <= inst.rd;
	end

	always_comb begin
		wb_next = '{valid: 1'b0, addr: inst.rd, data: result};
		if (accept) begin
			if (link)
				wb_next = '{valid: 1'b1, addr: reg_lr, data: {pc_next, 1'b0}};
			else if (!(mem_op || md_op || inst.jmp || inst.br))
				wb_next.valid = 1'b1;
		end else if (mem_end && r_load) begin
			wb_next = '{valid: 1'b1, addr: r_rd, data: ld_data};
		end else if (r_state == st_md_wait && md_done) begin
			wb_next = '{valid: 1'b1, addr: r_rd, data: md_lo};	// r7 already holds hi
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			r_wb.valid <= 1'b0;
		else
			r_wb.valid <= wb_next.valid;
	end

	always_ff @(posedge clk) begin
		r_wb.addr <= wb_next.addr;
		r_wb.data <= wb_next.data;
	end

endmodule

`default_nettype wire

// File: mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access
	import cpu_pkg::*;
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      accept,
	input  dec_inst_t inst,
	input  word_t     result,
	input  word_t     store_val,
	input  logic      rdone,
	input  word_t     rdata,
	input  logic      wdone,
	output mem_req_t  mem,
	output logic      load_wait,
	output logic      store_wait,
	output word_t     ld_data
);

	addr_t      r_addr;
	word_t      r_wdata, r_ld_data;
	wmask_t     r_wmask, c_mask;
	logic [1:0] r_rstrobe, c_strobe;
	logic [1:0] r_bsel;	// byte within word
	logic       r_byte;
	logic [7:0] ld_byte;
	logic       do_load, do_store;

	assign do_load = accept && inst.load;
	assign do_store = accept && inst.store;

	always_comb begin
		c_mask = inst.byte_sz ? wmask_t'(1) << result[1:0] : wmask_all;
		c_strobe = inst.byte_sz ? {result[1], ~result[1]} : 2'b11;
		ld_byte = rdata[8*r_bsel +: 8];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r_wmask <= '0;
			r_rstrobe <= '0;
		end else begin
			if (do_store)
				r_wmask <= c_mask;
			else if (wdone && |r_wmask)
				r_wmask <= '0;
			if (do_load)
				r_rstrobe <= c_strobe;
			else if (rdone && |r_rstrobe)
				r_rstrobe <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (do_load || do_store) begin
			r_addr <= result[xlen-1:2];
			r_bsel <= result[1:0];
			r_byte <= inst.byte_sz;
		end
		if (do_store)
			r_wdata <= inst.byte_sz ? {mask_w{store_val[7:0]}} : store_val;
		if (rdone && |r_rstrobe)
			r_ld_data <= r_byte ? {{(xlen-8){ld_byte[7]}}, ld_byte} : rdata;	// sign extend bytes
	end

	assign mem = '{addr: r_addr, wdata: r_wdata, wmask: r_wmask, rstrobe: r_rstrobe};
	assign load_wait = |r_rstrobe;
	assign store_wait = |r_wmask;
	assign ld_data = r_ld_data;

endmodule

`default_nettype wire

// File: exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top
	import cpu_pkg::*;
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  dec_inst_t inst,
	input  logic      iready,
	input  logic      idone,
	input  logic      rdone,
	input  word_t     rdata,
	input  logic      wdone,
	output pc_t       pc,
	output logic      ifetch,
	output mem_req_t  mem
);

	word_t a, b, store_val, result;
	word_t md_lo, md_hi, ld_data;
	logic  taken, accept;
	logic  md_busy, md_done;
	logic  load_wait, store_wait;
	logic  start_mul, start_div;
	wb_t   wb;

	assign start_mul = accept & inst.mult;
	assign start_div = accept & inst.div;

	reg_file u_reg_file (
		.clk(clk), .reset(reset),
		.rs1(inst.rs1), .rs2(inst.rs2),
		.needs_rs2(inst.needs_rs2), .imm(inst.imm),
		.wb(wb), .md_hi(md_hi),
		.a(a), .b(b), .store_val(store_val)
	);

	alu u_alu (
		.op(inst.op), .cond(inst.cond),
		.a(a), .b(b),
		.result(result), .taken(taken)
	);

	muldiv_unit u_muldiv (
		.clk(clk), .reset(reset),
		.start_mul(start_mul), .start_div(start_div),
		.a(a), .b(b), .wb(wb),
		.busy(md_busy), .done(md_done), .lo(md_lo), .md_hi(md_hi)
	);

	seq_control u_seq (
		.clk(clk), .reset(reset),
		.inst(inst), .iready(iready), .idone(idone),
		.result(result), .taken(taken),
		.md_busy(md_busy), .md_done(md_done), .md_lo(md_lo),
		.load_wait(load_wait), .store_wait(store_wait), .ld_data(ld_data),
		.accept(accept), .pc(pc), .ifetch(ifetch), .wb(wb)
	);

	mem_access u_mem (
		.clk(clk), .reset(reset),
		.accept(accept), .inst(inst),
		.result(result), .store_val(store_val),
		.rdone(rdone), .rdata(rdata), .wdone(wdone),
		.mem(mem), .load_wait(load_wait), .store_wait(store_wait), .ld_data(ld_data)
	);

endmodule

`default_nettype wire

// File: tb_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec
	import cpu_pkg::*;
	import bus_pkg::*;
();

	localparam int timeout_cycles = 4000;	// program needs about 1000
	localparam int mem_words = 64;

	logic      clk, reset;
	dec_inst_t inst;
	logic      iready, idone, rdone, wdone;
	word_t     rdata;
	pc_t       pc;
	logic      ifetch;
	mem_req_t  mem;

	word_t       mem_model [mem_words];
	word_t       ref_mem [mem_words];
	word_t       ref_regs [16];
	logic [30:0] ref_pc;
	dec_inst_t   prog [$];
	mem_req_t    exp_stores [$];
	mem_req_t    exp_loads [$];
	mem_req_t    exp;
	dec_inst_t   next_inst;
	logic [15:0] lfsr;
	logic        fetch_checked;
	int err_count, base_errs, test_count, test_fails, cycle_count;
	int fetch_st, f_cnt, rd_st, r_cnt, wr_st, w_cnt;
	int i, k;
	word_t v, addr;
	logic [9:0] t;

	exec_top UUT (
		.clk(clk), .reset(reset), .inst(inst), .iready(iready), .idone(idone),
		.rdone(rdone), .rdata(rdata), .wdone(wdone), .pc(pc), .ifetch(ifetch), .mem(mem)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic word_t fill_word(int idx);
		return word_t'(idx) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
	endfunction

	// 16-bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int j = 0; j < n; j++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			r = {r[30:0], lfsr[15]};
			lfsr = {lfsr[14:0], fb};
		end
		return r;
	endfunction

	function automatic int mem_delay();
		return 1 + int'(rand_bits(2)) % 3;
	endfunction

	function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
		word_t s;
		s = a + b;
		case (op)
		op_sub:   return a - b;
		op_xor:   return a ^ b;
		op_or:    return a | b;
		op_and:   return a & b;
		op_sll:   return a << b[4:0];
		op_sra:   return $signed(a) >>> b[4:0];
		op_srl:   return a >> b[4:0];
		op_addb:  return {{24{s[7]}}, s[7:0]};
		op_addbu: return {24'd0, s[7:0]};
		op_swap:  return {16'd0, b[7:0], b[15:8]};
		default:  return s;
		endcase
	endfunction

	function automatic logic ref_taken(br_cond_e c, word_t a);
		case (c)
		cond_eqz:    return a == 0;
		cond_nez:    return a != 0;
		cond_gez:    return !a[31];
		cond_ltz:    return a[31];
		cond_always: return 1'b1;
		default:     return 1'b0;
		endcase
	endfunction

	function automatic word_t ref_read(reg_idx_t r);
		if (r == 0 || (r >= 3 && r <= 6))
			return '0;	// unimplemented registers
		return ref_regs[r];
	endfunction

	function automatic void ref_write(reg_idx_t r, word_t val);
		if (r == 1 || r == 2 || r == 7 || r >= 8)
			ref_regs[r] = val;
	endfunction

	function automatic void ref_step(dec_inst_t in);
		word_t a, b, res, w, data;
		logic [63:0] prod;
		wmask_t mask;
		int idx;
		logic [30:0] pc_inc;
		a = ref_read(in.rs1);
		b = in.needs_rs2 ? ref_read(in.rs2) : in.imm;
		res = ref_alu(in.op, a, b);
		idx = int'(res[7:2]);
		pc_inc = ref_pc + 1'b1;
		ref_pc = pc_inc;
		if (in.load) begin
			exp_loads.push_back('{addr: res[31:2], wdata: '0, wmask: '0,
				rstrobe: in.byte_sz ? (2'b01 << res[1]) : 2'b11});
			w = ref_mem[idx];
			if (in.byte_sz) begin
				w = w >> (8 * res[1:0]);
				w = {{24{w[7]}}, w[7:0]};
			end
			ref_write(in.rd, w);
		end else if (in.store) begin
			data = ref_read(in.rs2);
			if (in.byte_sz) begin
				data = {4{data[7:0]}};
				mask = 4'b0001 << res[1:0];
			end else begin
				mask = 4'hf;
			end
			exp_stores.push_back('{addr: res[31:2], wdata: data, wmask: mask, rstrobe: 2'b00});
			for (int j = 0; j < 4; j++)
				if (mask[j])
					ref_mem[idx][8*j +: 8] = data[8*j +: 8];
		end else if (in.mult) begin
			prod = {32'd0, a} * {32'd0, b};
			ref_write(reg_mdhi, prod[63:32]);
			ref_write(in.rd, prod[31:0]);
		end else if (in.div) begin
			ref_write(reg_mdhi, b == 0 ? '0 : a % b);
			ref_write(in.rd, b == 0 ? '0 : a / b);
		end else if (in.jmp) begin
			if (in.cond[0])
				ref_write(reg_lr, {pc_inc, 1'b0});
			ref_pc = res[31:1];
		end else if (in.br) begin
			if (ref_taken(in.cond, a))
				ref_pc = res[31:1];
		end else begin
			ref_write(in.rd, res);
		end
	endfunction

	function automatic dec_inst_t blank();
		dec_inst_t d;
		d = '0;
		d.op = op_add;
		d.cond = cond_eqz;
		return d;
	endfunction

	function automatic dec_inst_t alu_ri(alu_op_e op, reg_idx_t rd, reg_idx_t rs1, word_t imm);
		dec_inst_t d;
		d = blank();
		d.op = op;
		d.rd = rd;
		d.rs1 = rs1;
		d.imm = imm;
		return d;
	endfunction

	function automatic dec_inst_t alu_rr(alu_op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		dec_inst_t d;
		d = alu_ri(op, rd, rs1, '0);
		d.rs2 = rs2;
		d.needs_rs2 = 1'b1;
		return d;
	endfunction

	// r is the store data register or the load destination
	function automatic dec_inst_t mem_i(logic st, logic bsz, reg_idx_t r, reg_idx_t base, word_t imm);
		dec_inst_t d;
		d = alu_ri(op_add, r, base, imm);
		d.rs2 = r;
		d.store = st;
		d.load = !st;
		d.byte_sz = bsz;
		return d;
	endfunction

	function automatic dec_inst_t md_i(logic is_div, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		dec_inst_t d;
		d = alu_rr(op_add, rd, rs1, rs2);
		d.mult = !is_div;
		d.div = is_div;
		return d;
	endfunction

	function automatic dec_inst_t br_i(br_cond_e c, reg_idx_t rs1, word_t imm);
		dec_inst_t d;
		d = alu_ri(op_add, reg_zero, rs1, imm);
		d.br = 1'b1;
		d.cond = c;
		return d;
	endfunction

	function automatic dec_inst_t jmp_i(logic link, reg_idx_t rs1, word_t imm);
		dec_inst_t d;
		d = alu_ri(op_add, reg_zero, rs1, imm);
		d.jmp = 1'b1;
		d.cond = link ? cond_always : cond_eqz;
		return d;
	endfunction

	// waits until the program is used up and the next fetch pc was checked
	task automatic run_program();
		do @(negedge clk); while (!(prog.size() == 0 && fetch_checked));
	endtask

	task automatic finish_test(string name);
		assert (exp_stores.size() == 0 && exp_loads.size() == 0) else begin
			$display("%0d stores and %0d loads of the program never reached the bus",
				exp_stores.size(), exp_loads.size());
			err_count++;
		end
		test_count++;
		if (err_count != base_errs)
			test_fails++;
		$display("test %0d %s: %s", test_count, name, err_count == base_errs ? "pass" : "fail");
		base_errs = err_count;
	endtask

	// memory model with fetch, load and store responders
	always @(posedge clk) begin
		if (reset) begin
			idone <= 1'b0;
			iready <= 1'b0;
			rdone <= 1'b0;
			wdone <= 1'b0;
			fetch_st = 0;
			rd_st = 0;
			wr_st = 0;
			fetch_checked = 1'b0;
		end else begin
			case (fetch_st)
			0: if (ifetch) begin
				if (!fetch_checked) begin
					assert (pc == ref_pc) else begin
						$display("Error at %0t ns: fetch pc %h, expected %h", $time, pc, ref_pc);
						err_count++;
					end
					fetch_checked = 1'b1;
				end
				if (prog.size() > 0) begin
					f_cnt = mem_delay();
					fetch_st = 1;
				end
			end
			1: if (f_cnt > 1) f_cnt--; else begin
				idone <= 1'b1;
				fetch_st = 2;
			end
			2: begin
				idone <= 1'b0;
				next_inst = prog.pop_front();
				inst <= next_inst;
				iready <= 1'b1;
				ref_step(next_inst);
				fetch_checked = 1'b0;
				fetch_st = 3;
			end
			default: begin
				iready <= 1'b0;	// accepted this cycle
				fetch_st = 0;
			end
			endcase

			case (rd_st)
			0: if (|mem.rstrobe) begin
				assert (exp_loads.size() > 0) else begin
					$display("unexpected load from word address %h at %0t ns", mem.addr, $time);
					err_count++;
				end
				if (exp_loads.size() > 0) begin
					exp = exp_loads.pop_front();
					assert (mem.addr == exp.addr && mem.rstrobe == exp.rstrobe) else begin
						$display("Error at %0t ns: load %h/%h, expected %h/%h", $time,
							mem.addr, mem.rstrobe, exp.addr, exp.rstrobe);
						err_count++;
					end
				end
				r_cnt = mem_delay();
				rd_st = 1;
			end
			1: if (r_cnt > 1) r_cnt--; else begin
				rdone <= 1'b1;
				rdata <= mem_model[mem.addr[5:0]];
				rd_st = 2;
			end
			default: begin
				rdone <= 1'b0;
				rd_st = 0;
			end
			endcase

			case (wr_st)
			0: if (|mem.wmask) begin
				assert (exp_stores.size() > 0) else begin
					$display("unexpected store to word address %h at %0t ns", mem.addr, $time);
					err_count++;
				end
				if (exp_stores.size() > 0) begin
					exp = exp_stores.pop_front();
					assert (mem.addr == exp.addr && mem.wdata == exp.wdata
							&& mem.wmask == exp.wmask) else begin
						$display("Error at %0t ns: store %h/%h/%h, expected %h/%h/%h", $time,
							mem.addr, mem.wdata, mem.wmask, exp.addr, exp.wdata, exp.wmask);
						err_count++;
					end
				end
				w_cnt = mem_delay();
				wr_st = 1;
			end
			1: if (w_cnt > 1) w_cnt--; else begin
				wdone <= 1'b1;
				for (int j = 0; j < 4; j++)
					if (mem.wmask[j])
						mem_model[mem.addr[5:0]][8*j +: 8] = mem.wdata[8*j +: 8];
				wr_st = 2;
			end
			default: begin
				wdone <= 1'b0;
				wr_st = 0;
			end
			endcase
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the stage stopped making progress after %0d cycles", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		lfsr = 16'd80;
		err_count = 0;
		base_errs = 0;
		test_count = 0;
		test_fails = 0;
		cycle_count = 0;
		reset = 1'b1;
		inst = '0;
		iready = 1'b0;
		idone = 1'b0;
		rdone = 1'b0;
		rdata = '0;
		wdone = 1'b0;
		for (i = 0; i < mem_words; i++) begin
			mem_model[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		for (i = 0; i < 16; i++)
			ref_regs[i] = '0;
		ref_pc = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		assert (ifetch && mem.wmask == 0 && mem.rstrobe == 0) else begin
			$display("Error at %0t ns: bad state after reset", $time);
			err_count++;
		end
		run_program();
		finish_test("reset state");

		for (i = 0; i < 11; i++) begin
			prog.push_back(alu_ri(op_add, 4'd8, reg_zero, rand_bits(32)));
			prog.push_back(alu_ri(op_add, 4'd9, reg_zero, rand_bits(32)));
			prog.push_back(alu_rr(alu_op_e'(4'(i)), 4'd10, 4'd8, 4'd9));
			prog.push_back(mem_i(1'b1, 1'b0, 4'd10, reg_zero, 4 * i));
		end
		run_program();
		finish_test("alu ops");

		prog.push_back(alu_ri(op_add, 4'd11, reg_zero, 32'd64));	// base register
		for (i = 0; i < 6; i++) begin
			addr = rand_bits(8);
			prog.push_back(alu_ri(op_add, 4'd12, reg_zero, rand_bits(32)));
			prog.push_back(mem_i(1'b1, i[0], 4'd12, 4'd11, addr - 64));
			prog.push_back(mem_i(1'b0, 1'b1, 4'd13, 4'd11, addr - 64));
			prog.push_back(mem_i(1'b0, 1'b0, 4'd14, 4'd11, addr - 64));
			prog.push_back(mem_i(1'b1, 1'b0, 4'd13, reg_zero, 32'd248));
			prog.push_back(mem_i(1'b1, 1'b0, 4'd14, reg_zero, 32'd252));
		end
		run_program();
		finish_test("loads and stores");

		for (i = 0; i < 5; i++) begin
			prog.push_back(alu_ri(op_add, 4'd8, reg_zero, rand_bits(32)));
			v = i == 4 ? '0 : (i >= 2 ? rand_bits(12) + 1 : rand_bits(32));	// last one divides by 0
			prog.push_back(alu_ri(op_add, 4'd9, reg_zero, v));
			prog.push_back(md_i(i >= 2, 4'd10, 4'd8, 4'd9));
			prog.push_back(mem_i(1'b1, 1'b0, 4'd10, reg_zero, 4 * (16 + 2 * i)));
			prog.push_back(mem_i(1'b1, 1'b0, reg_mdhi, reg_zero, 4 * (17 + 2 * i)));
		end
		run_program();
		finish_test("multiply and divide");

		for (i = 0; i < 4; i++) begin
			for (k = 0; k < 2; k++) begin
				v = rand_bits(32);
				case (i)
				0: v = k ? '0 : v | 1;
				1: v = k ? v | 1 : '0;
				2: v = k ? v & 32'h7fff_ffff : v | 32'h8000_0000;
				default: v = k ? v | 32'h8000_0000 : v & 32'h7fff_ffff;
				endcase
				t = rand_bits(10);
				prog.push_back(alu_ri(op_add, 4'd8, reg_zero, v));
				prog.push_back(br_i(br_cond_e'(3'(i)), 4'd8, (word_t'(t) << 1) - v));
			end
		end
		t = rand_bits(10);
		prog.push_back(jmp_i(1'b1, reg_zero, word_t'(t) << 1));
		prog.push_back(mem_i(1'b1, 1'b0, reg_lr, reg_zero, 32'd8));
		prog.push_back(jmp_i(1'b0, reg_lr, '0));	// return through lr
		run_program();
		finish_test("branches and jumps");

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			test_count, test_count - test_fails, test_fails, err_count);
		if (err_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
cpu_pkg.sv
bus_pkg.sv
reg_file.sv
alu.sv
muldiv_unit.sv
seq_control.sv
mem_access.sv
exec_top.sv
tb_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_exec -f filelist.f -o sim_exec

out=$(./obj_dir/sim_exec)
echo "$out"

if grep -qx "Test OK" <<< "$out"; then
	exit 0
else
	exit 1
fi
